/* rtl/rename_pkg.sv */
`default_nettype none

package rename_pkg;

  localparam int DISP_SIZE    = 2;
  localparam int TGT_BUS_SIZE = 2;
  localparam int LREG_W       = 5;
  localparam int RNID_SIZE    = 64;
  localparam int RNID_W       = 6;
  localparam int INST_W       = 32;

  // Format bit values, same position in both views
  localparam logic FMT_R = 1'b0;
  localparam logic FMT_I = 1'b1;

  typedef struct packed {
    logic              fmt;
    logic              wr_rd;
    logic [LREG_W-1:0] rd;
    logic [LREG_W-1:0] rs1;
    logic [LREG_W-1:0] rs2;
    logic [INST_W-2-3*LREG_W-1:0] op;    // Opcode bits, not decoded here
  } inst_r_t;

  typedef struct packed {
    logic              fmt;
    logic              wr_rd;
    logic [LREG_W-1:0] rd;
    logic [LREG_W-1:0] rs1;
    logic [INST_W-2-2*LREG_W-1:0] imm;
  } inst_i_t;

  // One instruction word, two views
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_t;

endpackage

`default_nettype wire

/* rtl/select_latest.sv */
`default_nettype none

module select_latest #(
  parameter int SEL_WIDTH = 2,
  parameter int KEY_WIDTH = 6
) (
  input  logic [KEY_WIDTH-1:0] i_cmp_key,
  input  logic [SEL_WIDTH-1:0] i_valid,
  input  logic [KEY_WIDTH-1:0] i_keys [SEL_WIDTH],
  input  logic [SEL_WIDTH-1:0] i_data,
  output logic                 o_valid,
  output logic                 o_data
);

  // Scan upward so the highest matching index wins
  always_comb begin
    o_valid = 1'b0;
    o_data  = 1'b0;
    for (int k = 0; k < SEL_WIDTH; k++) begin
      if (i_valid[k] && (i_keys[k] == i_cmp_key)) begin
        o_valid = 1'b1;
        o_data  = i_data[k];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rename_ctrl.sv */
`default_nettype none

module rename_ctrl #(
  parameter int DISP_SIZE = rename_pkg::DISP_SIZE
) (
  input  logic [DISP_SIZE-1:0]          i_disp_valid,
  input  rename_pkg::inst_t             i_disp_inst [DISP_SIZE],
  input  logic [rename_pkg::RNID_W-1:0] i_free_count,
  output logic                          o_stall,
  output logic                          o_fire,
  output logic [DISP_SIZE-1:0]          o_alloc_req,
  output logic [rename_pkg::LREG_W-1:0] o_rd_lreg [DISP_SIZE],
  output logic [rename_pkg::LREG_W-1:0] o_rs_lreg [DISP_SIZE*2],
  output logic [DISP_SIZE*2-1:0]        o_src_used
);

  import rename_pkg::*;

  logic [DISP_SIZE-1:0] w_wr_rd;
  logic [DISP_SIZE-1:0] w_rs2_used;
  logic [RNID_W-1:0]    w_need_cnt;

  // Format bit picks the union view
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_wr_rd[d]        = 1'b0;
      w_rs2_used[d]     = 1'b0;
      o_rd_lreg[d]      = '0;
      o_rs_lreg[2*d]    = '0;
      o_rs_lreg[2*d+1]  = '0;
      case (i_disp_inst[d].r.fmt)
        FMT_R: begin
          w_wr_rd[d]       = i_disp_inst[d].r.wr_rd;
          o_rd_lreg[d]     = i_disp_inst[d].r.rd;
          o_rs_lreg[2*d]   = i_disp_inst[d].r.rs1;
          o_rs_lreg[2*d+1] = i_disp_inst[d].r.rs2;
          w_rs2_used[d]    = 1'b1;
        end
        FMT_I: begin
          w_wr_rd[d]       = i_disp_inst[d].i.wr_rd;
          o_rd_lreg[d]     = i_disp_inst[d].i.rd;
          o_rs_lreg[2*d]   = i_disp_inst[d].i.rs1;
        end
      endcase
    end
  end

  always_comb begin
    w_need_cnt = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      // x0 as destination needs no register
      o_alloc_req[d] = i_disp_valid[d] & w_wr_rd[d] & (o_rd_lreg[d] != '0);
      o_src_used[2*d]   = (o_rs_lreg[2*d] != '0);
      o_src_used[2*d+1] = w_rs2_used[d] & (o_rs_lreg[2*d+1] != '0);
      if (o_alloc_req[d]) begin
        w_need_cnt = w_need_cnt + 1'b1;
      end
    end
  end

  assign o_stall = (w_need_cnt > i_free_count);
  assign o_fire  = (|i_disp_valid) & ~o_stall;   // Single accept for all blocks

endmodule

`default_nettype wire

/* rtl/rename_map.sv */
`default_nettype none

module rename_map #(
  parameter int DISP_SIZE = rename_pkg::DISP_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_fire,
  input  logic [DISP_SIZE-1:0]          i_alloc_req,
  input  logic [rename_pkg::LREG_W-1:0] i_rd_lreg [DISP_SIZE],
  input  logic [rename_pkg::LREG_W-1:0] i_rs_lreg [DISP_SIZE*2],
  input  logic [rename_pkg::RNID_W-1:0] i_alloc_rnid [DISP_SIZE],
  output logic [rename_pkg::RNID_W-1:0] o_rs_rnid [DISP_SIZE*2],
  output logic [rename_pkg::RNID_W-1:0] o_old_rnid [DISP_SIZE]
);

  import rename_pkg::*;

  localparam int LREG_NUM = 2**LREG_W;

  logic [RNID_W-1:0] r_map [LREG_NUM];

  // Table read, then override with earlier slots of the group
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_old_rnid[d]    = r_map[i_rd_lreg[d]];
      o_rs_rnid[2*d]   = r_map[i_rs_lreg[2*d]];
      o_rs_rnid[2*d+1] = r_map[i_rs_lreg[2*d+1]];
      for (int p = 0; p < d; p++) begin
        if (i_alloc_req[p]) begin
          if (i_rd_lreg[p] == i_rd_lreg[d]) begin
            o_old_rnid[d] = i_alloc_rnid[p];   // Second write to same rd
          end
          for (int s = 0; s < 2; s++) begin
            if (i_rd_lreg[p] == i_rs_lreg[2*d+s]) begin
              o_rs_rnid[2*d+s] = i_alloc_rnid[p];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int l = 0; l < LREG_NUM; l++) begin
        r_map[l] <= RNID_W'(l);    // Identity mapping
      end
    end else if (i_fire) begin
      // Slot order, last write wins
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_alloc_req[d]) begin
          r_map[i_rd_lreg[d]] <= i_alloc_rnid[d];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/free_list.sv */
`default_nettype none

module free_list #(
  parameter int DISP_SIZE = rename_pkg::DISP_SIZE,
  parameter int RNID_SIZE = rename_pkg::RNID_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_fire,
  input  logic [DISP_SIZE-1:0]          i_alloc_req,
  input  logic [DISP_SIZE-1:0]          i_free_valid,
  input  logic [rename_pkg::RNID_W-1:0] i_free_rnid [DISP_SIZE],
  output logic [rename_pkg::RNID_W-1:0] o_alloc_rnid [DISP_SIZE],
  output logic [rename_pkg::RNID_W-1:0] o_free_count
);

  import rename_pkg::*;

  localparam int LREG_NUM  = 2**LREG_W;
  localparam int FREE_SIZE = RNID_SIZE - LREG_NUM;
  localparam int PTR_W     = $clog2(FREE_SIZE);

  logic [RNID_W-1:0] r_queue [FREE_SIZE];
  logic [PTR_W-1:0]  r_head;
  logic [PTR_W-1:0]  r_tail;
  logic [RNID_W-1:0] r_count;

  logic [RNID_W-1:0] w_pop_cnt;
  logic [RNID_W-1:0] w_push_cnt;
  logic [PTR_W-1:0]  w_push_ptr [DISP_SIZE];

  // Requesting slots take consecutive entries from the head
  always_comb begin
    int pop_ofs;
    int push_ofs;
    pop_ofs  = 0;
    push_ofs = 0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_alloc_rnid[d] = r_queue[r_head + PTR_W'(pop_ofs)];
      w_push_ptr[d]   = r_tail + PTR_W'(push_ofs);
      if (i_alloc_req[d]) begin
        pop_ofs = pop_ofs + 1;
      end
      if (i_free_valid[d]) begin
        push_ofs = push_ofs + 1;
      end
    end
    w_pop_cnt  = i_fire ? RNID_W'(pop_ofs) : '0;
    w_push_cnt = RNID_W'(push_ofs);
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < FREE_SIZE; e++) begin
        r_queue[e] <= RNID_W'(LREG_NUM + e);
      end
      r_head  <= '0;
      r_tail  <= '0;    // Full queue, tail wrapped onto head
      r_count <= RNID_W'(FREE_SIZE);
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_free_valid[d]) begin
          r_queue[w_push_ptr[d]] <= i_free_rnid[d];
        end
      end
      r_head  <= r_head + PTR_W'(w_pop_cnt);
      r_tail  <= r_tail + PTR_W'(w_push_cnt);
      r_count <= r_count + w_push_cnt - w_pop_cnt;
    end
  end

  assign o_free_count = r_count;

endmodule

`default_nettype wire

/* rtl/inflight_list.sv */
`default_nettype none

module inflight_list #(
  parameter int DISP_SIZE    = rename_pkg::DISP_SIZE,
  parameter int TGT_BUS_SIZE = rename_pkg::TGT_BUS_SIZE,
  parameter int RNID_SIZE    = rename_pkg::RNID_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic [rename_pkg::RNID_W-1:0] i_rnid [DISP_SIZE*2],
  input  logic [DISP_SIZE*2-1:0]        i_src_used,
  input  logic [DISP_SIZE-1:0]          i_alloc_valid,
  input  logic [rename_pkg::RNID_W-1:0] i_alloc_rnid [DISP_SIZE],
  input  logic [TGT_BUS_SIZE-1:0]       i_wb_valid,
  input  logic [rename_pkg::RNID_W-1:0] i_wb_rnid [TGT_BUS_SIZE],
  output logic [DISP_SIZE*2-1:0]        o_ready
);

  logic [RNID_SIZE-1:0] r_ready;
  logic [RNID_SIZE-1:0] w_set;
  logic [RNID_SIZE-1:0] w_clr;

  always_comb begin
    w_set = '0;
    w_clr = '0;
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (i_wb_valid[b]) begin
        w_set[i_wb_rnid[b]] = 1'b1;
      end
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (i_alloc_valid[d]) begin
        w_clr[i_alloc_rnid[d]] = 1'b1;
      end
    end
  end

  // Clear beats set; bit 0 stays ready
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ready <= '1;
    end else begin
      r_ready <= ((r_ready | w_set) & ~w_clr) | RNID_SIZE'(1);
    end
  end

  for (genvar s = 0; s < DISP_SIZE*2; s++) begin : g_src
    logic w_alloc_hit;
    logic w_alloc_data;
    logic w_wb_hit;
    logic w_wb_data;

    // New allocation in this group, not ready yet
    select_latest #(
      .SEL_WIDTH(DISP_SIZE),
      .KEY_WIDTH(rename_pkg::RNID_W)
    ) u_sel_alloc (
      .i_cmp_key(i_rnid[s]),
      .i_valid  (i_alloc_valid),
      .i_keys   (i_alloc_rnid),
      .i_data   ('0),
      .o_valid  (w_alloc_hit),
      .o_data   (w_alloc_data)
    );

    // Writeback bus this cycle
    select_latest #(
      .SEL_WIDTH(TGT_BUS_SIZE),
      .KEY_WIDTH(rename_pkg::RNID_W)
    ) u_sel_wb (
      .i_cmp_key(i_rnid[s]),
      .i_valid  (i_wb_valid),
      .i_keys   (i_wb_rnid),
      .i_data   ('1),
      .o_valid  (w_wb_hit),
      .o_data   (w_wb_data)
    );

    assign o_ready[s] = !i_src_used[s]    ? 1'b1 :
                        (i_rnid[s] == '0) ? 1'b1 :
                        w_wb_hit          ? w_wb_data :
                        w_alloc_hit       ? w_alloc_data :
                        r_ready[i_rnid[s]];
  end

endmodule

`default_nettype wire

/* rtl/rename_top.sv */
`default_nettype none

module rename_top #(
  parameter int DISP_SIZE    = rename_pkg::DISP_SIZE,
  parameter int TGT_BUS_SIZE = rename_pkg::TGT_BUS_SIZE,
  parameter int RNID_SIZE    = rename_pkg::RNID_SIZE
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic [DISP_SIZE-1:0]          i_disp_valid,
  input  rename_pkg::inst_t             i_disp_inst [DISP_SIZE],
  input  logic [TGT_BUS_SIZE-1:0]       i_wb_valid,
  input  logic [rename_pkg::RNID_W-1:0] i_wb_rnid [TGT_BUS_SIZE],
  input  logic [DISP_SIZE-1:0]          i_free_valid,
  input  logic [rename_pkg::RNID_W-1:0] i_free_rnid [DISP_SIZE],
  output logic                          o_stall,
  output logic [rename_pkg::RNID_W-1:0] o_rs_rnid [DISP_SIZE*2],
  output logic [DISP_SIZE*2-1:0]        o_rs_ready,
  output logic [rename_pkg::RNID_W-1:0] o_rd_rnid [DISP_SIZE],
  output logic [rename_pkg::RNID_W-1:0] o_old_rnid [DISP_SIZE]
);

  import rename_pkg::*;

  logic                 w_fire;
  logic [DISP_SIZE-1:0] w_alloc_req;
  logic [DISP_SIZE-1:0] w_alloc_fired;
  logic [LREG_W-1:0]    w_rd_lreg [DISP_SIZE];
  logic [LREG_W-1:0]    w_rs_lreg [DISP_SIZE*2];
  logic [DISP_SIZE*2-1:0] w_src_used;
  logic [RNID_W-1:0]    w_free_count;

  assign w_alloc_fired = w_alloc_req & {DISP_SIZE{w_fire}};  // Only accepted groups

  rename_ctrl #(
    .DISP_SIZE(DISP_SIZE)
  ) u_ctrl (
    .i_disp_valid(i_disp_valid),
    .i_disp_inst (i_disp_inst),
    .i_free_count(w_free_count),
    .o_stall     (o_stall),
    .o_fire      (w_fire),
    .o_alloc_req (w_alloc_req),
    .o_rd_lreg   (w_rd_lreg),
    .o_rs_lreg   (w_rs_lreg),
    .o_src_used  (w_src_used)
  );

  rename_map #(
    .DISP_SIZE(DISP_SIZE)
  ) u_map (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_fire      (w_fire),
    .i_alloc_req (w_alloc_req),
    .i_rd_lreg   (w_rd_lreg),
    .i_rs_lreg   (w_rs_lreg),
    .i_alloc_rnid(o_rd_rnid),
    .o_rs_rnid   (o_rs_rnid),
    .o_old_rnid  (o_old_rnid)
  );

  free_list #(
    .DISP_SIZE(DISP_SIZE),
    .RNID_SIZE(RNID_SIZE)
  ) u_free (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_fire      (w_fire),
    .i_alloc_req (w_alloc_req),
    .i_free_valid(i_free_valid),
    .i_free_rnid (i_free_rnid),
    .o_alloc_rnid(o_rd_rnid),
    .o_free_count(w_free_count)
  );

  inflight_list #(
    .DISP_SIZE   (DISP_SIZE),
    .TGT_BUS_SIZE(TGT_BUS_SIZE),
    .RNID_SIZE   (RNID_SIZE)
  ) u_inflight (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_rnid       (o_rs_rnid),
    .i_src_used   (w_src_used),
    .i_alloc_valid(w_alloc_fired),
    .i_alloc_rnid (o_rd_rnid),
    .i_wb_valid   (i_wb_valid),
    .i_wb_rnid    (i_wb_rnid),
    .o_ready      (o_rs_ready)
  );

endmodule

`default_nettype wire

/* test/rename_model.svh */
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Reference state of the rename stage
logic [RNID_W-1:0] m_map [32];
logic [RNID_W-1:0] m_free [$];
logic [RNID_W-1:0] m_pending [$];   // Old rnids waiting to be freed
logic              m_ready [RNID_SIZE];

// Predictions for the cycle being checked
logic                 exp_stall;
logic                 exp_fire;
logic [DISP_SIZE-1:0] exp_need;
logic [RNID_W-1:0]    exp_rs [DISP_SIZE*2];
logic                 exp_ready [DISP_SIZE*2];
logic [RNID_W-1:0]    exp_rd [DISP_SIZE];
logic [RNID_W-1:0]    exp_old [DISP_SIZE];
logic [RNID_W-1:0]    exp_map [32];

task automatic model_reset();
  m_free.delete();
  m_pending.delete();
  for (int l = 0; l < 32; l++) begin
    m_map[l] = RNID_W'(l);
    m_free.push_back(RNID_W'(l + 32));
  end
  for (int r = 0; r < RNID_SIZE; r++) begin
    m_ready[r] = 1'b1;
  end
endtask

task automatic model_predict();
  int                k;
  int                cnt;
  logic [4:0]        rd;
  logic [4:0]        rs [2];
  logic              used [2];
  logic [RNID_W-1:0] grp_alloc [$];
  cnt = 0;
  for (int d = 0; d < DISP_SIZE; d++) begin
    exp_need[d] = cur_valid[d] && cur_inst[d][30] && (cur_inst[d][29:25] != 0);
    cnt = cnt + int'(exp_need[d]);
  end
  exp_stall = cnt > m_free.size();
  exp_fire  = (cur_valid != 0) && !exp_stall;
  exp_map   = m_map;
  k = 0;
  for (int d = 0; d < DISP_SIZE; d++) begin
    rd      = cur_inst[d][29:25];
    rs[0]   = cur_inst[d][24:20];
    rs[1]   = cur_inst[d][31] ? 5'd0 : cur_inst[d][19:15];   // Immediate view has no rs2
    used[0] = rs[0] != 0;
    used[1] = rs[1] != 0;
    exp_old[d] = exp_map[rd];
    for (int s = 0; s < 2; s++) begin
      exp_rs[2*d+s] = exp_map[rs[s]];
      exp_ready[2*d+s] = m_ready[exp_rs[2*d+s]];
      foreach (grp_alloc[a]) begin
        if (grp_alloc[a] == exp_rs[2*d+s]) exp_ready[2*d+s] = 1'b0;
      end
      for (int b = 0; b < TGT_BUS_SIZE; b++) begin
        if (cur_wb_valid[b] && cur_wb_rnid[b] == exp_rs[2*d+s]) exp_ready[2*d+s] = 1'b1;
      end
      if (!used[s] || exp_rs[2*d+s] == 0) exp_ready[2*d+s] = 1'b1;
    end
    exp_rd[d] = (exp_need[d] && k < m_free.size()) ? m_free[k] : '0;
    if (exp_need[d]) begin
      exp_map[rd] = exp_rd[d];
      if (exp_fire) grp_alloc.push_back(exp_rd[d]);
      k++;
    end
  end
endtask

task automatic model_commit();
  if (exp_fire) begin
    m_map = exp_map;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (exp_need[d]) begin
        void'(m_free.pop_front());
        m_ready[exp_rd[d]] = 1'b0;
        m_pending.push_back(exp_old[d]);
      end
    end
  end
  for (int b = 0; b < TGT_BUS_SIZE; b++) begin
    if (cur_wb_valid[b]) m_ready[cur_wb_rnid[b]] = 1'b1;
  end
  for (int d = 0; d < DISP_SIZE; d++) begin
    if (cur_free_valid[d]) m_free.push_back(cur_free_rnid[d]);
  end
endtask

`endif

/* test/tb_rename.sv */
`default_nettype none

module tb_rename;

  import rename_pkg::*;

  logic                    i_clk;
  logic                    i_reset_n;
  logic [DISP_SIZE-1:0]    disp_valid;
  inst_t                   disp_inst [DISP_SIZE];
  logic [TGT_BUS_SIZE-1:0] wb_valid;
  logic [RNID_W-1:0]       wb_rnid [TGT_BUS_SIZE];
  logic [DISP_SIZE-1:0]    free_valid;
  logic [RNID_W-1:0]       free_rnid [DISP_SIZE];
  logic                    stall;
  logic [RNID_W-1:0]       rs_rnid [DISP_SIZE*2];
  logic [DISP_SIZE*2-1:0]  rs_ready;
  logic [RNID_W-1:0]       rd_rnid [DISP_SIZE];
  logic [RNID_W-1:0]       old_rnid [DISP_SIZE];

  // Values driven this cycle as the model sees them
  logic [DISP_SIZE-1:0]    cur_valid;
  logic [INST_W-1:0]       cur_inst [DISP_SIZE];
  logic [TGT_BUS_SIZE-1:0] cur_wb_valid;
  logic [RNID_W-1:0]       cur_wb_rnid [TGT_BUS_SIZE];
  logic [DISP_SIZE-1:0]    cur_free_valid;
  logic [RNID_W-1:0]       cur_free_rnid [DISP_SIZE];

  logic [15:0] lfsr = 16'd2683;
  string       cur_test;
  int          test_err;
  int          err_total;
  int          checks;
  logic        stall_seen;
  logic [RNID_W-1:0] r5;

  `include "rename_model.svh"

  rename_top DUT (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_disp_valid(disp_valid),
    .i_disp_inst (disp_inst),
    .i_wb_valid  (wb_valid),
    .i_wb_rnid   (wb_rnid),
    .i_free_valid(free_valid),
    .i_free_rnid (free_rnid),
    .o_stall     (stall),
    .o_rs_rnid   (rs_rnid),
    .o_rs_ready  (rs_ready),
    .o_rd_rnid   (rd_rnid),
    .o_old_rnid  (old_rnid)
  );

  always #50 i_clk = ~i_clk;

  function automatic logic lfsr_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 16'hB400;
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_r(input logic wr, input logic [4:0] rd, rs1, rs2);
    return {1'b0, wr, rd, rs1, rs2, 15'b0};
  endfunction

  function automatic logic [31:0] make_i(input logic wr, input logic [4:0] rd, rs1,
                                         input logic [19:0] imm);
    return {1'b1, wr, rd, rs1, imm};
  endfunction

  task automatic check_rnid(input string what, input logic [RNID_W-1:0] exp_v, act_v);
    checks++;
    if (exp_v !== act_v) begin
      $display("error %s %s expected %0d actual %0d", cur_test, what, exp_v, act_v);
      test_err++;
    end
  endtask

  task automatic check_flag(input string what, input logic exp_v, act_v);
    checks++;
    if (exp_v !== act_v) begin
      $display("error %s %s expected %0b actual %0b", cur_test, what, exp_v, act_v);
      test_err++;
    end
  endtask

  // wb_mode picks no writeback (0), a random in-flight one (1) or wb_force (2)
  task automatic drive_group(input logic [DISP_SIZE-1:0] valid, input logic [31:0] i0, i1,
                             input int wb_mode, input logic [RNID_W-1:0] wb_force,
                             input logic allow_free);
    logic [RNID_W-1:0] busy [$];
    int                found;
    @(posedge i_clk);
    cur_valid   = valid;
    cur_inst[0] = i0;
    cur_inst[1] = i1;
    for (int r = 1; r < RNID_SIZE; r++) begin
      if (!m_ready[r]) busy.push_back(RNID_W'(r));
    end
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      cur_wb_valid[b] = 1'b0;
      cur_wb_rnid[b]  = '0;
      if (wb_mode == 1 && busy.size() > 0 && rand_bits(1)) begin
        cur_wb_valid[b] = 1'b1;
        cur_wb_rnid[b]  = busy[rand_bits(6) % busy.size()];
      end
    end
    if (wb_mode == 2) begin
      cur_wb_valid[0] = 1'b1;
      cur_wb_rnid[0]  = wb_force;
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      cur_free_valid[d] = 1'b0;
      cur_free_rnid[d]  = '0;
      found = -1;
      if (allow_free && rand_bits(1)) begin
        for (int i = 0; i < m_pending.size(); i++) begin
          if (found < 0 && m_ready[m_pending[i]]) found = i;
        end
      end
      if (found >= 0) begin
        cur_free_valid[d] = 1'b1;
        cur_free_rnid[d]  = m_pending[found];
        m_pending.delete(found);
      end
    end
    disp_valid <= cur_valid;
    wb_valid   <= cur_wb_valid;
    free_valid <= cur_free_valid;
    for (int d = 0; d < DISP_SIZE; d++) begin
      disp_inst[d] <= inst_t'(cur_inst[d]);
      free_rnid[d] <= cur_free_rnid[d];
    end
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      wb_rnid[b] <= cur_wb_rnid[b];
    end
  endtask

  task automatic sample_cycle(output logic fired);
    @(negedge i_clk);
    model_predict();
    check_flag("stall", exp_stall, stall);
    if (exp_stall) stall_seen = 1'b1;
    if (!exp_stall) begin
      for (int s = 0; s < DISP_SIZE*2; s++) begin
        check_rnid($sformatf("rs%0d rnid", s), exp_rs[s], rs_rnid[s]);
        check_flag($sformatf("rs%0d ready", s), exp_ready[s], rs_ready[s]);
      end
    end
    if (exp_fire) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (exp_need[d]) begin
          check_rnid($sformatf("rd%0d rnid", d), exp_rd[d], rd_rnid[d]);
          check_rnid($sformatf("old%0d rnid", d), exp_old[d], old_rnid[d]);
        end
      end
    end
    model_commit();
    fired = exp_fire;
  endtask

  // Repeats the group until accepted and lets frees through after three stalls
  task automatic issue(input logic [DISP_SIZE-1:0] valid, input logic [31:0] i0, i1,
                       input int wb_mode, input logic [RNID_W-1:0] wb_force,
                       input logic freeze);
    int   stalls;
    logic fired;
    stalls = 0;
    do begin
      drive_group(valid, i0, i1, wb_mode, wb_force, !freeze || stalls >= 3);
      sample_cycle(fired);
      if (!fired && valid != 0) stalls++;
      if (stalls > 200) begin
        $display("timeout: dispatch group still stalled after 200 cycles");
        $display("Checks failed");
        $finish;
      end
    end while (!fired && valid != 0);
  endtask

  task automatic random_group(input logic freeze);
    logic [31:0] i0;
    logic [31:0] i1;
    i0 = rand_bits(32);
    i1 = rand_bits(32);
    i0[30] = rand_bits(2) != 0;
    i1[30] = rand_bits(2) != 0;
    if (rand_bits(2) == 0) i1[29:25] = i0[29:25];   // Same rd twice
    if (rand_bits(2) == 0) i1[24:20] = i0[29:25];   // Bypass to slot 1
    issue(2'(rand_bits(2)), i0, i1, 1, '0, freeze);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err = 0;
  endtask

  task automatic end_test();
    if (test_err == 0) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, test_err);
    err_total += test_err;
  endtask

  initial begin
    i_clk      = 1'b0;
    i_reset_n  = 1'b0;
    disp_valid = '0;
    wb_valid   = '0;
    free_valid = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      disp_inst[d] = '0;
      free_rnid[d] = '0;
    end
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      wb_rnid[b] = '0;
    end
    err_total  = 0;
    checks     = 0;
    stall_seen = 1'b0;
    model_reset();
    repeat (10) @(posedge i_clk);
    i_reset_n <= 1'b1;

    start_test("reset_identity");
    for (int l = 0; l < 32; l += 4) begin
      issue(2'b00, make_r(0, 0, 5'(l), 5'(l + 1)), make_r(0, 0, 5'(l + 2), 5'(l + 3)),
            0, '0, 1'b0);
    end
    end_test();

    start_test("group_bypass");
    issue(2'b11, make_r(1, 7, 3, 4), make_r(1, 7, 7, 7), 0, '0, 1'b0);
    issue(2'b11, make_i(1, 9, 7, 0), make_r(1, 10, 9, 7), 0, '0, 1'b0);
    end_test();

    start_test("ready_tracking");
    issue(2'b11, make_r(1, 5, 1, 2), make_r(0, 0, 5, 0), 0, '0, 1'b0);
    r5 = m_map[5];
    issue(2'b00, make_r(0, 0, 5, 0), '0, 0, '0, 1'b0);
    check_flag("x5 in flight", 1'b0, rs_ready[0]);
    issue(2'b00, make_r(0, 0, 5, 0), '0, 2, r5, 1'b0);
    check_flag("x5 writeback same cycle", 1'b1, rs_ready[0]);
    issue(2'b00, make_r(0, 0, 5, 0), '0, 0, '0, 1'b0);
    check_flag("x5 after writeback", 1'b1, rs_ready[0]);
    end_test();

    start_test("zero_regs");
    issue(2'b11, make_i(1, 0, 0, 20'h4_8000), make_r(1, 0, 0, 0), 0, '0, 1'b0);
    for (int s = 0; s < DISP_SIZE*2; s++) begin
      check_flag($sformatf("x0 src%0d ready", s), 1'b1, rs_ready[s]);
    end
    end_test();

    start_test("stall_freeze");
    for (int g = 0; g < 40; g++) begin
      issue(2'b11, make_r(1, 5'(g % 31 + 1), 5'(g), 3), make_r(1, 5'(g % 29 + 2), 6, 7),
            1, '0, 1'b1);
    end
    if (!stall_seen) begin
      $display("no stall was seen while frees were withheld");
      test_err++;
    end
    end_test();

    start_test("random_recycle");
    for (int g = 0; g < 400; g++) begin
      random_group(g % 100 > 80);
    end
    end_test();

    $display("checks %0d, errors %0d", checks, err_total);
    if (err_total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+test
rtl/rename_pkg.sv
rtl/select_latest.sv
rtl/rename_ctrl.sv
rtl/rename_map.sv
rtl/free_list.sv
rtl/inflight_list.sv
rtl/rename_top.sv
test/tb_rename.sv

/* Makefile */
SIM   = verilator
FLAGS = --timing -Wno-fatal
TOP   = tb_rename
FLIST = compile.f

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -o V$(TOP)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf obj_dir
